//--- capture_ctrl.sv
module capture_ctrl
    import la_pkg::*;
#(
    parameter int SAMPLE_DEPTH = 64,
    localparam int PTR_W = $clog2(SAMPLE_DEPTH)
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             start_req_i,
    input  logic             stop_req_i,
    input  logic [PTR_W-1:0] trig_loc_i,
    input  logic             trig_i,
    output cap_state_t       state_o,
    output logic [PTR_W-1:0] wptr_o,
    output logic             we_o
);

    logic             start_q;
    logic             stop_q;
    logic             start_edge;
    logic             stop_edge;
    logic [PTR_W-1:0] rptr_q;
    logic [PTR_W-1:0] wptr_next;

    assign start_edge = start_req_i && !start_q;
    assign stop_edge  = stop_req_i && !stop_q;
    // pointers wrap on their own since the depth is a power of two
    assign wptr_next  = wptr_o + 1'b1;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_o <= IDLE;
            wptr_o  <= '0;
            rptr_q  <= '0;
            we_o    <= 1'b0;
            start_q <= 1'b0;
            stop_q  <= 1'b0;
        end else begin
            start_q <= start_req_i;
            stop_q  <= stop_req_i;
            case (state_o)
                IDLE: begin
                    wptr_o <= '0;
                    rptr_q <= '0;
                    if (start_edge) begin
                        state_o <= MOVE_TO_POSITION;
                        we_o    <= 1'b1;
                    end
                end
                MOVE_TO_POSITION: begin
                    wptr_o <= wptr_next;
                    if (wptr_o == trig_loc_i)
                        state_o <= trig_i ? CAPTURING : IN_POSITION;
                end
                IN_POSITION: begin
                    // the pre-trigger window slides along with the write pointer
                    wptr_o <= wptr_next;
                    rptr_q <= rptr_q + 1'b1;
                    if (trig_i)
                        state_o <= CAPTURING;
                end
                CAPTURING: begin
                    if (wptr_next == rptr_q) begin
                        we_o    <= 1'b0;
                        state_o <= CAPTURED;
                    end else begin
                        wptr_o <= wptr_next;
                    end
                end
                CAPTURED: we_o <= 1'b0;
                default:  state_o <= IDLE;
            endcase
            if (stop_edge) begin
                state_o <= IDLE;
                we_o    <= 1'b0;
            end
        end
    end

    a_no_write_when_done: assert property (@(posedge clk) disable iff (rst_i)
        (state_o inside {IDLE, CAPTURED}) |-> !we_o)
        else $error("capture_ctrl writes samples while idle or captured");

endmodule

//--- cmd_decoder.sv
module cmd_decoder
    import la_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  byte_t    rx_data_i,
    input  logic     rx_valid_i,
    output bus_req_t req_o
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } dec_state_t;

    dec_state_t  state_q;
    logic [3:0]  count_q;
    logic [31:0] digits_q;
    logic [3:0]  last_count;
    logic        is_term;

    // only upper case hex digits are accepted
    function automatic logic is_hex(input byte_t c);
        return ((c >= "0") && (c <= "9")) || ((c >= "A") && (c <= "F"));
    endfunction

    function automatic logic [3:0] hex_val(input byte_t c);
        if (c <= "9")
            return 4'(c - "0");
        return 4'(c - "A" + 8'd10);
    endfunction

    // read takes four digits, write takes eight
    assign last_count = (state_q == WRITE) ? 4'd8 : 4'd4;
    assign is_term    = (rx_data_i == CH_CR) || (rx_data_i == CH_LF);

    // digit buffer, newest digit in the low nibble
    always_ff @(posedge clk) begin
        if (rx_valid_i && (state_q != IDLE) && is_hex(rx_data_i))
            digits_q <= {digits_q[27:0], hex_val(rx_data_i)};
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            count_q <= '0;
            req_o   <= '0;
        end else begin
            req_o.valid <= 1'b0;
            if (rx_valid_i) begin
                case (state_q)
                    IDLE: begin
                        count_q <= '0;
                        if (rx_data_i == CH_R)
                            state_q <= READ;
                        else if (rx_data_i == CH_W)
                            state_q <= WRITE;
                    end
                    READ, WRITE: begin
                        if (count_q == last_count) begin
                            state_q <= IDLE;
                            if (is_term) begin
                                req_o.valid <= 1'b1;
                                req_o.rw    <= (state_q == WRITE);
                                req_o.addr  <= (state_q == WRITE) ? digits_q[31:16]
                                                                  : digits_q[15:0];
                                req_o.data  <= (state_q == WRITE) ? digits_q[15:0] : '0;
                            end
                        end else if (is_hex(rx_data_i)) begin
                            count_q <= count_q + 4'd1;
                        end else begin
                            state_q <= IDLE;
                        end
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    a_no_back_to_back: assert property (@(posedge clk) disable iff (rst_i)
        req_o.valid |=> !req_o.valid)
        else $error("cmd_decoder issued requests on consecutive cycles");

endmodule

//--- la_pkg.sv
package la_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    // one probe word, sampled every clock
    typedef struct packed {
        logic       vsync;
        logic       hsync;
        logic       pix_valid;
        logic [7:0] pix_data;
    } probe_t;

    // request and response on the bus chain share one layout
    typedef struct packed {
        word_t addr;
        word_t data;
        logic  rw;
        logic  valid;
    } bus_req_t;

    typedef enum logic [3:0] {
        DISABLE  = 4'd0,
        RISING   = 4'd1,
        FALLING  = 4'd2,
        CHANGING = 4'd3,
        GT       = 4'd4,
        LT       = 4'd5,
        GEQ      = 4'd6,
        LEQ      = 4'd7,
        EQ       = 4'd8,
        NEQ      = 4'd9
    } trig_op_t;

    typedef struct packed {
        trig_op_t   data_op;
        logic [7:0] data_arg;
        trig_op_t   sync_op;
        logic       sync_arg;
    } trig_cfg_t;

    typedef enum logic [2:0] {
        IDLE             = 3'd0,
        MOVE_TO_POSITION = 3'd1,
        IN_POSITION      = 3'd2,
        CAPTURING        = 3'd3,
        CAPTURED         = 3'd4
    } cap_state_t;

    // register map
    localparam word_t REG_STATE    = 16'd0;
    localparam word_t REG_TRIG_LOC = 16'd1;
    localparam word_t REG_START    = 16'd2;
    localparam word_t REG_STOP     = 16'd3;
    localparam word_t REG_WPTR     = 16'd4;
    localparam word_t REG_DATA_OP  = 16'd5;
    localparam word_t REG_DATA_ARG = 16'd6;
    localparam word_t REG_SYNC_OP  = 16'd7;
    localparam word_t REG_SYNC_ARG = 16'd8;
    localparam word_t MEM_BASE     = 16'd256;

    localparam byte_t CH_R  = 8'h52;
    localparam byte_t CH_W  = 8'h57;
    localparam byte_t CH_D  = 8'h44;
    localparam byte_t CH_CR = 8'h0D;
    localparam byte_t CH_LF = 8'h0A;

endpackage

//--- la_regs.sv
module la_regs
    import la_pkg::*;
#(
    parameter int SAMPLE_DEPTH = 64,
    localparam int PTR_W = $clog2(SAMPLE_DEPTH)
) (
    input  logic             clk,
    input  logic             rst_i,
    input  bus_req_t         req_i,
    output bus_req_t         req_o,
    input  cap_state_t       cap_state_i,
    input  logic [PTR_W-1:0] wptr_i,
    output trig_cfg_t        trig_cfg_o,
    output logic [PTR_W-1:0] trig_loc_o,
    output logic             start_req_o,
    output logic             stop_req_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_o       <= '0;
            trig_cfg_o  <= '0;
            trig_loc_o  <= '0;
            start_req_o <= 1'b0;
            stop_req_o  <= 1'b0;
        end else begin
            // every request moves down the chain one cycle later
            req_o <= req_i;

            if (req_i.valid && !req_i.rw) begin
                case (req_i.addr)
                    REG_STATE:    req_o.data <= word_t'(cap_state_i);
                    REG_TRIG_LOC: req_o.data <= word_t'(trig_loc_o);
                    REG_START:    req_o.data <= word_t'(start_req_o);
                    REG_STOP:     req_o.data <= word_t'(stop_req_o);
                    REG_WPTR:     req_o.data <= word_t'(wptr_i);
                    REG_DATA_OP:  req_o.data <= word_t'(trig_cfg_o.data_op);
                    REG_DATA_ARG: req_o.data <= word_t'(trig_cfg_o.data_arg);
                    REG_SYNC_OP:  req_o.data <= word_t'(trig_cfg_o.sync_op);
                    REG_SYNC_ARG: req_o.data <= word_t'(trig_cfg_o.sync_arg);
                    default:      req_o.data <= req_i.data;
                endcase
            end

            // state and write pointer are read only
            if (req_i.valid && req_i.rw) begin
                case (req_i.addr)
                    REG_TRIG_LOC: trig_loc_o <= req_i.data[PTR_W-1:0];
                    REG_START:    start_req_o <= req_i.data[0];
                    REG_STOP:     stop_req_o <= req_i.data[0];
                    REG_DATA_OP:  trig_cfg_o.data_op <= trig_op_t'(req_i.data[3:0]);
                    REG_DATA_ARG: trig_cfg_o.data_arg <= req_i.data[7:0];
                    REG_SYNC_OP:  trig_cfg_o.sync_op <= trig_op_t'(req_i.data[3:0]);
                    REG_SYNC_ARG: trig_cfg_o.sync_arg <= req_i.data[0];
                    default:      trig_loc_o <= trig_loc_o;
                endcase
            end
        end
    end

endmodule

//--- logic_analyzer.sv
module logic_analyzer
    import la_pkg::*;
#(
    parameter int SAMPLE_DEPTH = 64,
    localparam int PTR_W = $clog2(SAMPLE_DEPTH)
) (
    input  logic   clk,
    input  logic   rst_i,
    input  byte_t  rx_data_i,
    input  logic   rx_valid_i,
    input  logic   tx_done_i,
    input  probe_t probe_i,
    output byte_t  tx_data_o,
    output logic   tx_start_o
);

    bus_req_t         dec_req;
    bus_req_t         regs_req;
    bus_req_t         mem_rsp;
    trig_cfg_t        trig_cfg;
    logic [PTR_W-1:0] trig_loc;
    logic [PTR_W-1:0] wptr;
    logic             start_req;
    logic             stop_req;
    logic             trig;
    logic             we;
    cap_state_t       cap_state;

    cmd_decoder u_cmd_decoder (
        .clk        (clk),
        .rst_i      (rst_i),
        .rx_data_i  (rx_data_i),
        .rx_valid_i (rx_valid_i),
        .req_o      (dec_req)
    );

    la_regs #(.SAMPLE_DEPTH(SAMPLE_DEPTH)) u_la_regs (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (dec_req),
        .req_o       (regs_req),
        .cap_state_i (cap_state),
        .wptr_i      (wptr),
        .trig_cfg_o  (trig_cfg),
        .trig_loc_o  (trig_loc),
        .start_req_o (start_req),
        .stop_req_o  (stop_req)
    );

    trigger_match u_trigger_match (
        .clk        (clk),
        .rst_i      (rst_i),
        .probe_i    (probe_i),
        .trig_cfg_i (trig_cfg),
        .trig_o     (trig)
    );

    capture_ctrl #(.SAMPLE_DEPTH(SAMPLE_DEPTH)) u_capture_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_req_i (start_req),
        .stop_req_i  (stop_req),
        .trig_loc_i  (trig_loc),
        .trig_i      (trig),
        .state_o     (cap_state),
        .wptr_o      (wptr),
        .we_o        (we)
    );

    sample_memory #(.SAMPLE_DEPTH(SAMPLE_DEPTH)) u_sample_memory (
        .clk     (clk),
        .rst_i   (rst_i),
        .req_i   (regs_req),
        .req_o   (mem_rsp),
        .we_i    (we),
        .waddr_i (wptr),
        .probe_i (probe_i)
    );

    reply_encoder u_reply_encoder (
        .clk        (clk),
        .rst_i      (rst_i),
        .rsp_i      (mem_rsp),
        .tx_data_o  (tx_data_o),
        .tx_start_o (tx_start_o),
        .tx_done_i  (tx_done_i)
    );

endmodule

//--- reply_encoder.sv
module reply_encoder
    import la_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  bus_req_t rsp_i,
    output byte_t    tx_data_o,
    output logic     tx_start_o,
    input  logic     tx_done_i
);

    word_t      value_q;
    logic [2:0] count_q;
    logic       rsp_read;

    function automatic byte_t to_hex(input logic [3:0] n);
        return (n < 4'd10) ? ("0" + byte_t'(n)) : ("A" - 8'd10 + byte_t'(n));
    endfunction

    assign rsp_read = rsp_i.valid && !rsp_i.rw;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            tx_start_o <= 1'b0;
            count_q    <= '0;
        end else if (!tx_start_o) begin
            tx_start_o <= rsp_read;
            count_q    <= '0;
        end else if (tx_done_i) begin
            if (count_q == 3'd6) begin
                // a read arriving with the last done starts the next frame at once
                count_q    <= '0;
                tx_start_o <= rsp_read;
            end else begin
                count_q <= count_q + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_read && (!tx_start_o || (tx_done_i && (count_q == 3'd6))))
            value_q <= rsp_i.data;
    end

    always_comb begin
        case (count_q)
            3'd0:    tx_data_o = CH_D;
            3'd1:    tx_data_o = to_hex(value_q[15:12]);
            3'd2:    tx_data_o = to_hex(value_q[11:8]);
            3'd3:    tx_data_o = to_hex(value_q[7:4]);
            3'd4:    tx_data_o = to_hex(value_q[3:0]);
            3'd5:    tx_data_o = CH_CR;
            default: tx_data_o = CH_LF;
        endcase
    end

    a_count_in_frame: assert property (@(posedge clk) disable iff (rst_i)
        count_q <= 3'd6)
        else $error("reply_encoder byte counter ran past the frame");

endmodule

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_logic_analyzer \
    -f verilog.f -o tb_logic_analyzer
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_logic_analyzer)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1

//--- sample_memory.sv
module sample_memory
    import la_pkg::*;
#(
    parameter int SAMPLE_DEPTH = 64,
    localparam int PTR_W = $clog2(SAMPLE_DEPTH)
) (
    input  logic             clk,
    input  logic             rst_i,
    input  bus_req_t         req_i,
    output bus_req_t         req_o,
    input  logic             we_i,
    input  logic [PTR_W-1:0] waddr_i,
    input  probe_t           probe_i
);

    word_t            mem [SAMPLE_DEPTH];
    word_t            rdata_q;
    bus_req_t         req_q;
    logic             hit_q;
    logic             hit;
    logic [PTR_W-1:0] raddr;

    assign hit   = (req_i.addr >= MEM_BASE) && (req_i.addr < MEM_BASE + word_t'(SAMPLE_DEPTH));
    assign raddr = PTR_W'(req_i.addr - MEM_BASE);

    // capture side write port
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < SAMPLE_DEPTH; i++)
                mem[i] <= '0;
        end else if (we_i) begin
            mem[waddr_i] <= word_t'(probe_i);
        end
    end

    // bus side read, one register deep
    always_ff @(posedge clk) begin
        rdata_q <= mem[raddr];
    end

    // second stage lines the request up with the read data
    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_q <= '0;
            hit_q <= 1'b0;
            req_o <= '0;
        end else begin
            req_q <= req_i;
            hit_q <= hit;
            req_o <= req_q;
            if (req_q.valid && !req_q.rw && hit_q)
                req_o.data <= rdata_q;
        end
    end

endmodule

//--- tb_logic_analyzer.sv
module tb_logic_analyzer
    import la_pkg::*;
();

    localparam int    DEPTH         = 64;
    localparam int    FRAME_TIMEOUT = 300;
    localparam int    QUIET_CYCLES  = 200;
    localparam int    POLL_LIMIT    = 40;
    localparam byte_t TRIG_VALUE    = 8'hA5;

    logic   clk;
    logic   rst_i      = 1'b1;
    byte_t  rx_data_i  = '0;
    logic   rx_valid_i = 1'b0;
    logic   tx_done_i  = 1'b0;
    probe_t probe_i    = '0;
    byte_t  tx_data_o;
    logic   tx_start_o;

    // every byte the DUT hands to the transmitter, in order
    byte_t       tx_log[$];
    int unsigned tx_lcg    = 32'd6;
    int unsigned probe_lcg = 32'd6;
    int          tx_gap    = 0;
    logic        tx_busy   = 1'b0;
    int          errors    = 0;
    int          checks    = 0;
    int          frames    = 0;
    word_t       samples[DEPTH];

    logic_analyzer #(.SAMPLE_DEPTH(DEPTH)) i_dut (
        .clk        (clk),
        .rst_i      (rst_i),
        .rx_data_i  (rx_data_i),
        .rx_valid_i (rx_valid_i),
        .tx_done_i  (tx_done_i),
        .probe_i    (probe_i),
        .tx_data_o  (tx_data_o),
        .tx_start_o (tx_start_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // pixel data counts every cycle, the flag bits are noise
    always @(posedge clk) begin
        probe_lcg         <= lcg_next(probe_lcg);
        probe_i.pix_data  <= probe_i.pix_data + 8'd1;
        probe_i.pix_valid <= probe_lcg[16];
        probe_i.hsync     <= probe_lcg[17];
        probe_i.vsync     <= probe_lcg[18];
    end

    // external transmitter model, one done pulse per byte after a random gap
    always @(posedge clk) begin
        if (rst_i) begin
            tx_done_i <= 1'b0;
            tx_busy   <= 1'b0;
        end else begin
            tx_done_i <= 1'b0;
            if (tx_busy) begin
                if (tx_gap == 0) begin
                    tx_done_i <= 1'b1;
                    tx_busy   <= 1'b0;
                end else begin
                    tx_gap <= tx_gap - 1;
                end
            end else if (tx_start_o && !tx_done_i) begin
                tx_log.push_back(tx_data_o);
                tx_lcg  <= lcg_next(tx_lcg);
                tx_gap  <= int'(tx_lcg[17:16]) + 1;
                tx_busy <= 1'b1;
            end
        end
    end

    task automatic expect_equal(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic expect_true(input string name, input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s: %s", name, what);
        end
    endtask

    function automatic byte_t hex_char(input logic [3:0] n);
        if (n < 4'd10)
            return "0" + byte_t'(n);
        return "A" + byte_t'(n) - 8'd10;
    endfunction

    function automatic bit is_upper_hex(input byte_t c);
        return ((c >= "0") && (c <= "9")) || ((c >= "A") && (c <= "F"));
    endfunction

    function automatic logic [3:0] digit_value(input byte_t c);
        if (c <= "9")
            return 4'(c - "0");
        return 4'(c - "A" + 8'd10);
    endfunction

    task automatic send_byte(input byte_t b);
        @(posedge clk);
        rx_data_i  <= b;
        rx_valid_i <= 1'b1;
        @(posedge clk);
        rx_valid_i <= 1'b0;
    endtask

    task automatic send_hex(input word_t w);
        for (int i = 3; i >= 0; i--)
            send_byte(hex_char(w[i*4 +: 4]));
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++)
            send_byte(byte_t'(s[i]));
    endtask

    task automatic write_reg(input word_t addr, input word_t data);
        send_byte(CH_W);
        send_hex(addr);
        send_hex(data);
        send_byte(CH_CR);
    endtask

    // sends a read, waits for its seven byte reply and decodes the value
    task automatic read_reg(input string name, input word_t addr, output word_t value);
        int    base;
        int    waited;
        byte_t frame[7];
        base   = tx_log.size();
        waited = 0;
        value  = '0;
        frames++;
        send_byte(CH_R);
        send_hex(addr);
        send_byte(CH_LF);
        while ((tx_log.size() < base + 7) && (waited < FRAME_TIMEOUT)) begin
            @(negedge clk);
            waited++;
        end
        expect_true(name, tx_log.size() >= base + 7,
                    "no complete reply frame arrived in time");
        if (tx_log.size() < base + 7)
            return;
        for (int i = 0; i < 7; i++)
            frame[i] = tx_log[base + i];
        expect_equal({name, " lead byte"}, int'(CH_D), int'(frame[0]));
        for (int i = 1; i < 5; i++) begin
            checks++;
            assert (is_upper_hex(frame[i])) else begin
                errors++;
                $display("CHECK FAILED %s digit: expected upper-case hex, actual %02h",
                         name, frame[i]);
            end
            value = {value[11:0], digit_value(frame[i])};
        end
        expect_equal({name, " cr byte"}, int'(CH_CR), int'(frame[5]));
        expect_equal({name, " lf byte"}, int'(CH_LF), int'(frame[6]));
        // the encoder drops reads while a frame is still going out
        waited = 0;
        while (tx_start_o && (waited < FRAME_TIMEOUT)) begin
            @(negedge clk);
            waited++;
        end
        expect_true(name, !tx_start_o, "reply frame never finished");
    endtask

    task automatic wait_for_state(input string name, input cap_state_t want);
        word_t value;
        int    tries;
        tries = 0;
        read_reg(name, REG_STATE, value);
        while ((value != word_t'(want)) && (tries < POLL_LIMIT)) begin
            read_reg(name, REG_STATE, value);
            tries++;
        end
        expect_equal(name, int'(want), int'(value));
    endtask

    initial begin
        word_t value;
        int    mark;
        int    waited;
        int    breaks;
        bit    found;

        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        repeat (4) @(posedge clk);

        write_reg(REG_TRIG_LOC, 16'h0010);
        read_reg("trig_loc readback", REG_TRIG_LOC, value);
        expect_equal("trig_loc readback", 'h0010, int'(value));

        // lower case digits, wrong terminators and a stray leading byte
        mark = tx_log.size();
        send_text("W0001002a");
        send_byte(CH_CR);
        send_text("R000a");
        send_byte(CH_LF);
        send_text("W00010022 ");
        send_text("R0001 ");
        send_text("RW00010033");
        send_byte(CH_CR);
        send_text("WR0001");
        send_byte(CH_LF);
        waited = 0;
        while ((tx_log.size() == mark) && (waited < QUIET_CYCLES)) begin
            @(negedge clk);
            waited++;
        end
        expect_true("malformed commands", tx_log.size() == mark,
                    "a malformed command produced a reply frame");
        read_reg("trig_loc after malformed", REG_TRIG_LOC, value);
        expect_equal("trig_loc after malformed", 'h0010, int'(value));

        read_reg("unmapped read", 16'h0050, value);
        expect_equal("unmapped read", 0, int'(value));

        // capture around a pixel value match
        write_reg(REG_DATA_OP, word_t'(EQ));
        write_reg(REG_DATA_ARG, word_t'(TRIG_VALUE));
        write_reg(REG_SYNC_OP, word_t'(DISABLE));
        write_reg(REG_TRIG_LOC, 16'd16);
        write_reg(REG_START, 16'd0);
        write_reg(REG_START, 16'd1);
        wait_for_state("capture done", CAPTURED);

        for (int n = 0; n < DEPTH; n++)
            read_reg("sample read", MEM_BASE + word_t'(n), samples[n]);
        breaks = 0;
        found  = 1'b0;
        for (int n = 0; n < DEPTH; n++) begin
            if (samples[(n + 1) % DEPTH][7:0] != samples[n][7:0] + 8'd1)
                breaks++;
            if (samples[n][7:0] == TRIG_VALUE)
                found = 1'b1;
        end
        expect_true("sample order", breaks <= 1,
                    "captured pixel values break their counting order more than once");
        expect_true("trigger sample", found, "the trigger value is not in the captured samples");

        write_reg(REG_STOP, 16'd1);
        read_reg("stop after capture", REG_STATE, value);
        expect_equal("stop after capture", int'(IDLE), int'(value));

        // rearm with every trigger off, it must park in position
        write_reg(REG_STOP, 16'd0);
        write_reg(REG_DATA_OP, word_t'(DISABLE));
        write_reg(REG_START, 16'd0);
        write_reg(REG_START, 16'd1);
        wait_for_state("armed without trigger", IN_POSITION);
        write_reg(REG_STOP, 16'd1);
        read_reg("stop while armed", REG_STATE, value);
        expect_equal("stop while armed", int'(IDLE), int'(value));

        expect_equal("reply byte count", frames * 7, tx_log.size());
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- trigger_match.sv
module trigger_match
    import la_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  probe_t    probe_i,
    input  trig_cfg_t trig_cfg_i,
    output logic      trig_o
);

    probe_t prev_q;
    logic   data_hit;
    logic   sync_hit;

    // edge ops look at the previous sample, compare ops at the argument
    function automatic logic fire(input trig_op_t op, input logic [7:0] cur,
                                  input logic [7:0] prev, input logic [7:0] arg);
        case (op)
            RISING:   return cur > prev;
            FALLING:  return cur < prev;
            CHANGING: return cur != prev;
            GT:       return cur > arg;
            LT:       return cur < arg;
            GEQ:      return cur >= arg;
            LEQ:      return cur <= arg;
            EQ:       return cur == arg;
            NEQ:      return cur != arg;
            default:  return 1'b0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i)
            prev_q <= '0;
        else
            prev_q <= probe_i;
    end

    assign data_hit = fire(trig_cfg_i.data_op, probe_i.pix_data, prev_q.pix_data,
                           trig_cfg_i.data_arg);
    // vsync is widened so the same compare serves both triggers
    assign sync_hit = fire(trig_cfg_i.sync_op, {7'd0, probe_i.vsync}, {7'd0, prev_q.vsync},
                           {7'd0, trig_cfg_i.sync_arg});
    assign trig_o   = data_hit || sync_hit;

endmodule

//--- verilog.f
la_pkg.sv
cmd_decoder.sv
la_regs.sv
trigger_match.sv
capture_ctrl.sv
sample_memory.sv
reply_encoder.sv
logic_analyzer.sv
tb_logic_analyzer.sv
